//--- Makefile
TOP := rv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/rv_core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
    input wire                    clk,
    input wire                    arst_n,
    input wire                    retire_valid,
    input wire rv_pkg::reg_addr_t retire_rd,
    input wire rv_pkg::redirect_t redirect,
    input wire rv_pkg::exec_pkt_t exec_pkt
);

    int failures = 0;

    // x0 writes never reach the retirement port
    retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n)
        retire_valid |-> retire_rd != '0
    ) else begin
        $error("retire_valid is high with retire_rd of zero");
        failures++;
    end

    // Instruction behind a taken redirect is squashed
    flush_kills_next: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.taken |=> !exec_pkt.valid
    ) else begin
        $error("exec_pkt valid right after a redirect");
        failures++;
    end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .redirect     (redirect),
    .exec_pkt     (exec_pkt)
);

`default_nettype wire

//--- dv/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    typedef struct packed {
        logic [31:0] inst;
        logic        retires;
        logic [4:0]  rd;
        logic [31:0] data;
    } entry_t;

    localparam int RESET_CYCLES   = 5;
    localparam int RETIRE_TIMEOUT = 50;
    localparam int IDLE_CYCLES    = 30;

    logic        clk;
    logic        arst_n;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    entry_t      prog_table[$];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    rv_core uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sign_extend(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] alu_reg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_form(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] alu_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                            logic [11:0] imm);
        return i_form(imm, rs1, f3, rd, 7'b0010011);
    endfunction

    function automatic logic [31:0] upper(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(logic [4:0] rs2, logic [4:0] rs1,
                                               logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] cond_branch(logic [2:0] f3, logic [4:0] rs1,
                                                logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_entry(logic [31:0] inst, logic retires, logic [4:0] rd,
                             logic [31:0] data);
        entry_t e;
        e.inst    = inst;
        e.retires = retires;
        e.rd      = rd;
        e.data    = data;
        prog_table.push_back(e);
    endtask

    // Branch over three ADDIs that retire only on the fall-through path
    task automatic add_branch_block(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                    logic taken);
        logic [31:0] r;
        logic [11:0] v;
        logic [4:0]  rd;
        int          k;
        add_entry(cond_branch(f3, rs1, rs2, 13'd16), 1'b0, 5'd0, 32'd0);
        for (k = 0; k < 3; k++) begin
            r  = next_random();
            v  = r[27:16];
            rd = 5'd28 + 5'(k);
            add_entry(alu_imm(3'd0, rd, 5'd0, v), !taken, rd, sign_extend(v));
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] link;
        logic [31:0] pc;
        logic [31:0] off;
        logic [31:0] shadow;
        int          k;
        r  = next_random();
        a  = r[27:16];
        r  = next_random();
        b  = r[27:16];
        r  = next_random();
        c  = r[27:16];
        x1 = sign_extend(a);
        x2 = sign_extend(b);
        x3 = 32'h8000_1000;
        shadow = alu_imm(3'd0, 5'd30, 5'd0, 12'h7ff);
        add_entry(alu_imm(3'd0, 5'd1, 5'd0, a), 1'b1, 5'd1, x1);
        add_entry(alu_imm(3'd0, 5'd2, 5'd0, b), 1'b1, 5'd2, x2);
        add_entry(upper(20'h80001, 5'd3, 7'b0110111), 1'b1, 5'd3, x3);
        // AUIPC sits at byte address 12
        add_entry(upper(20'h12345, 5'd5, 7'b0010111), 1'b1, 5'd5, 32'h1234_500c);
        add_entry(alu_reg(7'h00, 3'd0, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, x1 + x2);
        add_entry(alu_reg(7'h20, 3'd0, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, x1 - x2);
        add_entry(alu_reg(7'h00, 3'd2, 5'd7, 5'd3, 5'd1), 1'b1, 5'd7,
                  ($signed(x3) < $signed(x1)) ? 32'd1 : 32'd0);
        add_entry(alu_reg(7'h00, 3'd3, 5'd8, 5'd3, 5'd1), 1'b1, 5'd8, (x3 < x1) ? 32'd1 : 32'd0);
        add_entry(alu_reg(7'h00, 3'd7, 5'd9, 5'd1, 5'd3), 1'b1, 5'd9, x1 & x3);
        add_entry(alu_reg(7'h00, 3'd6, 5'd10, 5'd1, 5'd2), 1'b1, 5'd10, x1 | x2);
        add_entry(alu_reg(7'h00, 3'd4, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, x1 ^ x2);
        add_entry(alu_imm(3'd0, 5'd12, 5'd0, 12'd5), 1'b1, 5'd12, 32'd5);
        add_entry(alu_reg(7'h00, 3'd1, 5'd13, 5'd1, 5'd2), 1'b1, 5'd13, x1 << x2[4:0]);
        add_entry(alu_reg(7'h00, 3'd5, 5'd14, 5'd3, 5'd2), 1'b1, 5'd14, x3 >> x2[4:0]);
        add_entry(alu_reg(7'h20, 3'd5, 5'd15, 5'd3, 5'd12), 1'b1, 5'd15,
                  {{5{x3[31]}}, x3[31:5]});
        add_entry(alu_imm(3'd2, 5'd16, 5'd1, c), 1'b1, 5'd16,
                  ($signed(x1) < $signed(sign_extend(c))) ? 32'd1 : 32'd0);
        add_entry(alu_imm(3'd3, 5'd17, 5'd1, c), 1'b1, 5'd17,
                  (x1 < sign_extend(c)) ? 32'd1 : 32'd0);
        add_entry(alu_imm(3'd4, 5'd18, 5'd2, c), 1'b1, 5'd18, x2 ^ sign_extend(c));
        add_entry(alu_imm(3'd6, 5'd19, 5'd2, c), 1'b1, 5'd19, x2 | sign_extend(c));
        add_entry(alu_imm(3'd7, 5'd20, 5'd2, c), 1'b1, 5'd20, x2 & sign_extend(c));
        add_entry(alu_imm(3'd1, 5'd21, 5'd1, 12'd7), 1'b1, 5'd21, x1 << 7);
        add_entry(alu_imm(3'd5, 5'd22, 5'd3, 12'd3), 1'b1, 5'd22, x3 >> 3);
        add_entry(alu_imm(3'd5, 5'd23, 5'd3, 12'h403), 1'b1, 5'd23, {{3{x3[31]}}, x3[31:3]});
        add_entry(alu_imm(3'd0, 5'd0, 5'd1, 12'd77), 1'b0, 5'd0, 32'd0);
        add_entry(alu_imm(3'd0, 5'd25, 5'd0, 12'h040), 1'b1, 5'd25, 32'h40);
        add_entry(alu_imm(3'd0, 5'd0, 5'd0, 12'd0), 1'b0, 5'd0, 32'd0);
        add_entry(alu_reg(7'h00, 3'd0, 5'd24, 5'd0, 5'd2), 1'b1, 5'd24, x2);
        add_entry(store_word(5'd4, 5'd25, 12'd8), 1'b0, 5'd0, 32'd0);
        add_entry(i_form(12'd8, 5'd25, 3'd2, 5'd26, 7'b0000011), 1'b1, 5'd26, x1 + x2);
        add_entry(store_word(5'd6, 5'd25, 12'hffc), 1'b0, 5'd0, 32'd0);
        add_entry(i_form(12'hffc, 5'd25, 3'd2, 5'd27, 7'b0000011), 1'b1, 5'd27, x1 - x2);
        add_branch_block(3'd0, 5'd12, 5'd12, 1'b1);
        add_branch_block(3'd1, 5'd12, 5'd12, 1'b0);
        add_branch_block(3'd4, 5'd3, 5'd12, $signed(x3) < $signed(32'd5));
        add_branch_block(3'd6, 5'd3, 5'd12, x3 < 32'd5);
        add_branch_block(3'd5, 5'd12, 5'd3, $signed(32'd5) >= $signed(x3));
        add_branch_block(3'd7, 5'd3, 5'd12, x3 >= 32'd5);
        link = 32'(prog_table.size()) * 32'd4 + 32'd4;
        add_entry(jump_link(5'd31, 21'd16), 1'b1, 5'd31, link);
        for (k = 0; k < 3; k++) begin
            add_entry(shadow, 1'b0, 5'd0, 32'd0);
        end
        // JALR target drops bit 0 of the odd offset and skips four words
        pc  = 32'(prog_table.size()) * 32'd4;
        off = pc + 32'd21 - link;
        add_entry(i_form(off[11:0], 5'd31, 3'd0, 5'd26, 7'b1100111), 1'b1, 5'd26, pc + 32'd4);
        for (k = 0; k < 4; k++) begin
            add_entry(shadow, 1'b0, 5'd0, 32'd0);
        end
        add_entry(alu_imm(3'd0, 5'd7, 5'd26, 12'd1), 1'b1, 5'd7, pc + 32'd5);
        add_entry(alu_reg(7'h00, 3'd0, 5'd0, 5'd1, 5'd2), 1'b0, 5'd0, 32'd0);
        // Park in a self loop
        add_entry(jump_link(5'd0, 21'd0), 1'b0, 5'd0, 32'd0);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    task automatic wait_retire(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    initial begin
        int i;
        bit ok;
        bit timed_out;
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        lcg_state = 32'd70259;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        build_program();

        // Program goes in while the core sits in reset
        for (i = 0; i < prog_table.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= prog_table[i].inst;
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        for (i = 0; i < prog_table.size() && !timed_out; i++) begin
            if (prog_table[i].retires) begin
                wait_retire(ok);
                if (!ok) begin
                    $display("Timeout at %0t: program word %0d never retired", $time, i);
                    errors++;
                    timed_out = 1'b1;
                end else begin
                    check_value("retire_rd", {27'd0, retire_rd}, {27'd0, prog_table[i].rd});
                    check_value("retire_data", retire_data, prog_table[i].data);
                end
            end
        end

        if (!timed_out) begin
            // Self loop retires nothing
            repeat (IDLE_CYCLES) begin
                @(negedge clk);
                if (retire_valid === 1'b1) begin
                    $display("Unexpected retirement of x%0d at %0t", retire_rd, $time);
                    errors++;
                end
            end
        end

        errors += uut.u_assertions.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire rv_pkg::fetch_pkt_t fetch,
    input  wire                     flush,
    input  wire rv_pkg::reg_write_t reg_write,
    output rv_pkg::decode_pkt_t     decoded
);

    rv_pkg::word_t       rf [2**$bits(rv_pkg::reg_addr_t)];
    rv_pkg::word_t       inst;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;
    rv_pkg::reg_addr_t   rs1;
    rv_pkg::reg_addr_t   rs2;
    rv_pkg::word_t       imm_i;
    rv_pkg::word_t       imm_s;
    rv_pkg::word_t       imm_b;
    rv_pkg::word_t       imm_u;
    rv_pkg::word_t       imm_j;
    rv_pkg::decode_pkt_t dec_d;

    assign inst   = fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // x0 reads zero and a write in flight is seen the same cycle
    function automatic rv_pkg::word_t read_rf(rv_pkg::reg_addr_t idx);
        rv_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (reg_write.valid && reg_write.rd == idx) begin
            val = reg_write.data;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    function automatic rv_pkg::alu_op_t arith_op(logic [2:0] f3, logic f7_alt, logic is_reg);
        rv_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = (f7_alt && is_reg) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (reg_write.valid && reg_write.rd != '0) begin
            rf[reg_write.rd] <= reg_write.data;
        end
    end

    always_comb begin
        dec_d         = '0;
        dec_d.valid   = fetch.valid & ~flush;
        dec_d.pc      = fetch.pc;
        dec_d.rd      = inst[11:7];
        dec_d.rs1_val = read_rf(rs1);
        dec_d.rs2_val = read_rf(rs2);
        dec_d.funct3  = funct3;
        dec_d.alu_op  = rv_pkg::ALU_NONE;
        case (opcode)
            rv_pkg::OPC_OP: begin
                dec_d.alu_op    = arith_op(funct3, alt, 1'b1);
                dec_d.writes_rd = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                dec_d.alu_op    = arith_op(funct3, alt, 1'b0);
                dec_d.imm       = imm_i;
                dec_d.use_imm   = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                dec_d.alu_op    = rv_pkg::ALU_PASS_B;
                dec_d.imm       = imm_u;
                dec_d.use_imm   = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                dec_d.alu_op    = rv_pkg::ALU_ADD;
                dec_d.imm       = imm_u;
                dec_d.use_imm   = 1'b1;
                dec_d.use_pc    = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                dec_d.alu_op    = rv_pkg::ALU_ADD;
                dec_d.imm       = imm_i;
                dec_d.use_imm   = 1'b1;
                dec_d.writes_rd = 1'b1;
                dec_d.is_load   = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                dec_d.alu_op   = rv_pkg::ALU_ADD;
                dec_d.imm      = imm_s;
                dec_d.use_imm  = 1'b1;
                dec_d.is_store = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                dec_d.imm       = imm_b;
                dec_d.is_branch = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                dec_d.imm       = imm_j;
                dec_d.is_jal    = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                dec_d.imm       = imm_i;
                dec_d.is_jalr   = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            default: begin
                // Unknown opcode passes through as a no-op
                dec_d.alu_op = rv_pkg::ALU_NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else begin
            decoded <= dec_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire rv_pkg::decode_pkt_t decoded,
    output rv_pkg::exec_pkt_t        executed,
    output rv_pkg::redirect_t        redirect
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t link;
    rv_pkg::word_t target;
    logic          cmp_true;
    logic          jump;
    logic          live;
    logic          take;

    assign op_a = decoded.use_pc  ? decoded.pc  : decoded.rs1_val;
    assign op_b = decoded.use_imm ? decoded.imm : decoded.rs2_val;

    always_comb begin
        case (decoded.alu_op)
            rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            rv_pkg::ALU_SLT:    alu_res = {31'b0, ($signed(op_a) < $signed(op_b))};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, (op_a < op_b)};
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (decoded.funct3)
            3'b000:  cmp_true = decoded.rs1_val == decoded.rs2_val;
            3'b001:  cmp_true = decoded.rs1_val != decoded.rs2_val;
            3'b100:  cmp_true = $signed(decoded.rs1_val) < $signed(decoded.rs2_val);
            3'b101:  cmp_true = $signed(decoded.rs1_val) >= $signed(decoded.rs2_val);
            3'b110:  cmp_true = decoded.rs1_val < decoded.rs2_val;
            3'b111:  cmp_true = decoded.rs1_val >= decoded.rs2_val;
            default: cmp_true = 1'b0;
        endcase
    end

    assign jump = decoded.is_jal | decoded.is_jalr;
    assign link = decoded.pc + 32'd4;

    // JALR target drops bit 0
    assign target = decoded.is_jalr ? ((decoded.rs1_val + decoded.imm) & ~32'd1)
                                    : (decoded.pc + decoded.imm);

    // Instruction right behind a taken redirect is on the wrong path
    assign live = decoded.valid & ~redirect.taken;
    assign take = live & (jump | (decoded.is_branch & cmp_true));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            executed <= '0;
            redirect <= '0;
        end else begin
            executed.valid      <= live;
            executed.rd         <= decoded.rd;
            executed.result     <= jump ? link : alu_res;
            executed.store_data <= decoded.rs2_val;
            executed.writes_rd  <= decoded.writes_rd;
            executed.is_load    <= decoded.is_load;
            executed.is_store   <= decoded.is_store;
            redirect.taken      <= take;
            redirect.target     <= target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     prog_we,
    input  wire rv_pkg::imem_addr_t prog_addr,
    input  wire rv_pkg::word_t      prog_data,
    input  wire rv_pkg::redirect_t  redirect,
    output rv_pkg::fetch_pkt_t      fetch
);

    rv_pkg::word_t      imem [rv_pkg::IMEM_DEPTH];
    rv_pkg::word_t      pc;
    rv_pkg::imem_addr_t pc_idx;

    // Word index of the current PC
    assign pc_idx = pc[2 +: $bits(rv_pkg::imem_addr_t)];

    // Load port stays open while reset is held
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            fetch <= '0;
        end else if (redirect.taken) begin
            // Wrong-path fetch becomes a bubble
            pc          <= redirect.target;
            fetch.valid <= 1'b0;
            fetch.pc    <= pc;
            fetch.inst  <= rv_pkg::NOP_INST;
        end else begin
            pc          <= pc + 32'd4;
            fetch.valid <= 1'b1;
            fetch.pc    <= pc;
            fetch.inst  <= imem[pc_idx];
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire rv_pkg::exec_pkt_t executed,
    output rv_pkg::reg_write_t     reg_write
);

    rv_pkg::word_t      dmem [rv_pkg::DMEM_DEPTH];
    rv_pkg::dmem_addr_t idx;
    rv_pkg::word_t      load_data;
    logic               retires;

    // Word index ignores the low two address bits
    assign idx       = executed.result[2 +: $bits(rv_pkg::dmem_addr_t)];
    assign load_data = dmem[idx];

    // Nothing retires for x0 or for non-writing instructions
    assign retires = executed.valid & executed.writes_rd & (executed.rd != '0);

    always_ff @(posedge clk) begin
        if (executed.valid && executed.is_store) begin
            dmem[idx] <= executed.store_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write <= '0;
        end else begin
            reg_write.valid <= retires;
            reg_write.rd    <= executed.rd;
            reg_write.data  <= executed.is_load ? load_data : executed.result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     prog_we,
    input  wire rv_pkg::imem_addr_t prog_addr,
    input  wire rv_pkg::word_t      prog_data,
    output logic                    retire_valid,
    output rv_pkg::reg_addr_t       retire_rd,
    output rv_pkg::word_t           retire_data
);

    rv_pkg::fetch_pkt_t  fetch_pkt;
    rv_pkg::decode_pkt_t decode_pkt;
    rv_pkg::exec_pkt_t   exec_pkt;
    rv_pkg::redirect_t   redirect;
    rv_pkg::reg_write_t  reg_write;

    fetch_stage u_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .redirect  (redirect),
        .fetch     (fetch_pkt)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch     (fetch_pkt),
        .flush     (redirect.taken),
        .reg_write (reg_write),
        .decoded   (decode_pkt)
    );

    execute_stage u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .decoded  (decode_pkt),
        .executed (exec_pkt),
        .redirect (redirect)
    );

    mem_wb_stage u_mem_wb (
        .clk       (clk),
        .arst_n    (arst_n),
        .executed  (exec_pkt),
        .reg_write (reg_write)
    );

    // Every register write is a retirement
    assign retire_valid = reg_write.valid;
    assign retire_rd    = reg_write.rd;
    assign retire_data  = reg_write.data;

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  imem_addr_t;
    typedef logic [7:0]  dmem_addr_t;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B,
        ALU_NONE
    } alu_op_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      use_pc;
        logic      writes_rd;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic [2:0] funct3;
        logic      is_jal;
        logic      is_jalr;
    } decode_pkt_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
        logic      writes_rd;
        logic      is_load;
        logic      is_store;
    } exec_pkt_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- rv_core.f
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv
